//--- logic/screen_pkg.sv
package screen_pkg;

	// visible area of the vga screen
	localparam int SCREEN_WIDTH = 640;
	localparam int SCREEN_HEIGHT = 480;

	// signed, so motion math can dip below zero before it is clamped
	localparam int COORD_W = $clog2((SCREEN_WIDTH > SCREEN_HEIGHT) ?
		SCREEN_WIDTH : SCREEN_HEIGHT) + 1;
	typedef logic signed [COORD_W-1:0] coord_t; // pixel coordinate

	localparam int SPRITE_SIZE = 32; // bird box edge in pixels
	localparam int FIXED_SHIFT = 6; // position fraction bits, 1/64 pixel

	localparam int INITIAL_X = 280; // column where a deployed bird appears
	localparam int BIRD_Y = 185; // the bird flies along this row only

	// rightmost top-left x that keeps the whole sprite on screen
	localparam int X_LIMIT = SCREEN_WIDTH - SPRITE_SIZE - 1;

endpackage

//--- logic/game_pkg.sv
package game_pkg;

	// vector types used across the game blocks
	typedef logic [7:0] rand_t; // one random byte
	typedef logic [3:0] life_t; // hits left on the bird
	typedef logic [1:0] speed_t; // speed level, sets the step size
	typedef logic [1:0] level_t; // game level
	typedef logic [7:0] score_t; // hit count, saturating

	localparam int START_LIFE = 3; // lives of a freshly deployed bird
	localparam int CHANCE_TO_CHANGE = 8; // random byte below this turns the bird
	localparam int RED_FRAMES = 32; // frames of red flashing after a hit

	// horizontal step per frame in 1/64 pixel: base + inc * speed
	localparam int STEP_BASE = 50;
	localparam int STEP_PER_SPEED = 20;

	localparam level_t LAST_LEVEL = 2'd3; // clearing this one wins the game

	typedef enum logic [1:0] {
		wait_start, // idle until the player starts
		deploy_bird, // waiting for a frame to place a new bird
		playing, // bird on screen
		game_won // all levels cleared, held until reset
	} ctrl_state_t;

endpackage

//--- logic/bird_ctrl_if.sv
`timescale 1ns/1ps

interface bird_ctrl_if
	import game_pkg::*;
();

	logic start_of_frame; // one clock per frame
	logic collision; // shot hit the bird, valid on frame clock
	logic deploy; // place a new bird, valid on frame clock
	life_t starting_life; // life loaded on deploy
	speed_t speed; // current speed level

	modport ctrl (
		output deploy,
		output starting_life,
		output speed,
		input collision,
		input start_of_frame
	);

	modport bird (
		input start_of_frame,
		input collision,
		input deploy,
		input starting_life,
		input speed
	);

endinterface

//--- logic/lfsr_random.sv
`timescale 1ns/1ps

module lfsr_random
	import game_pkg::*;
#(
	parameter rand_t LFSR_SEED = 8'hA5 // must be nonzero
) (
	input logic clk,
	input logic resetN,
	output rand_t random
);

	// taps x^8+x^6+x^5+x^4+1, maximal length of 255
	localparam rand_t TAPS = 8'hB8;

	rand_t lfsr_q;
	rand_t lfsr_next;

	// galois form: shift right, fold the outgoing bit back in
	always_comb begin
		lfsr_next = lfsr_q >> 1;
		if (lfsr_q[0]) begin
			lfsr_next = lfsr_next ^ TAPS;
		end
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			lfsr_q <= LFSR_SEED; // held through reset
		end else begin
			lfsr_q <= lfsr_next; // new byte every clock
		end
	end

	assign random = lfsr_q;

endmodule

//--- logic/bird_logic.sv
`timescale 1ns/1ps

module bird_logic
	import screen_pkg::*;
	import game_pkg::*;
#(
	parameter rand_t RANDOM_OFFSET = '0 // decorrelates birds sharing one lfsr
) (
	input logic clk,
	input logic resetN,
	bird_ctrl_if.bird bus,
	input rand_t random,
	output logic alive,
	output logic red,
	output coord_t bird_x
);

	localparam int FIX_W = COORD_W + FIXED_SHIFT; // x in 1/64 pixel
	localparam int RED_W = $clog2(RED_FRAMES + 1);

	localparam logic signed [FIX_W-1:0] X_MAX_FIX = FIX_W'(X_LIMIT << FIXED_SHIFT);
	localparam logic signed [FIX_W-1:0] X_START_FIX = FIX_W'(INITIAL_X << FIXED_SHIFT);
	localparam logic [RED_W-1:0] RED_LOAD = RED_W'(RED_FRAMES);

	typedef enum logic [1:0] {
		idle_state,
		right_state,
		left_state
	} wander_t;

	wander_t state;
	wander_t next_state;
	rand_t offset_rnd; // random byte after the per-bird offset
	logic signed [FIX_W-1:0] x_fix; // top-left x, fixed point
	logic signed [FIX_W-1:0] x_next;
	logic signed [FIX_W-1:0] step;
	life_t life;
	logic [RED_W-1:0] red_cnt; // frames of red left

	// wander decision, only committed on a frame clock
	always_comb begin
		offset_rnd = random + RANDOM_OFFSET; // 8-bit sum wraps mod 256
		next_state = state;
		if (offset_rnd < rand_t'(CHANCE_TO_CHANGE)) begin
			if (state == idle_state) begin
				next_state = (offset_rnd < rand_t'(CHANCE_TO_CHANGE / 2)) ?
					right_state : left_state;
			end else begin
				next_state = idle_state; // any turn out of motion stops it
			end
		end
	end

	// motion follows the state held during the past frame
	always_comb begin
		step = FIX_W'(STEP_BASE + STEP_PER_SPEED * int'(bus.speed));
		x_next = x_fix;
		case (state)
			right_state: begin
				if (x_fix < X_MAX_FIX) begin
					// clamp so the sprite never runs off the right edge
					x_next = (x_fix + step > X_MAX_FIX) ? X_MAX_FIX : x_fix + step;
				end
			end
			left_state: begin
				if (x_fix > '0) begin
					x_next = (x_fix < step) ? '0 : x_fix - step; // stop at column 0
				end
			end
			default: begin
				x_next = x_fix; // idle, hover in place
			end
		endcase
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			state <= idle_state;
			x_fix <= '0;
			life <= '0;
			red_cnt <= '0;
		end else if (bus.start_of_frame) begin
			state <= next_state;
			x_fix <= bus.deploy ? X_START_FIX : x_next; // new bird starts mid screen

			if (bus.collision) begin
				if (life != '0) begin
					life <= life - 1'b1; // no wrap on a hit while flashing dead
				end
				red_cnt <= RED_LOAD; // restart flashing
			end else begin
				if (bus.deploy) begin
					life <= bus.starting_life;
				end
				if (red_cnt != '0) begin
					red_cnt <= red_cnt - 1'b1;
				end
			end
		end
	end

	assign red = (red_cnt != '0);
	assign alive = (life != '0) || red; // keep showing until the flashing ends
	assign bird_x = coord_t'(x_fix[FIX_W-1:FIXED_SHIFT]); // drop the fraction

endmodule

//--- logic/hit_detect.sv
`timescale 1ns/1ps

module hit_detect
	import screen_pkg::*;
(
	input logic clk,
	input logic resetN,
	input logic start_of_frame,
	input logic shot_valid,
	input coord_t shot_x,
	input coord_t shot_y,
	input logic alive,
	input coord_t bird_x,
	output logic collision
);

	localparam coord_t BOX_SPAN = coord_t'(SPRITE_SIZE - 1);
	localparam coord_t BOX_TOP = coord_t'(BIRD_Y);
	localparam coord_t BOX_BOTTOM = coord_t'(BIRD_Y + SPRITE_SIZE - 1);

	logic shot_held; // a shot arrived during this frame
	coord_t held_x;
	coord_t held_y;
	logic in_box;

	// the frame clock closes the frame, a shot on that clock is dropped
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			shot_held <= 1'b0;
		end else if (start_of_frame) begin
			shot_held <= 1'b0;
		end else if (shot_valid) begin
			shot_held <= 1'b1;
		end
	end

	// last shot of the frame wins
	always_ff @(posedge clk) begin
		if (shot_valid && !start_of_frame) begin
			held_x <= shot_x;
			held_y <= shot_y;
		end
	end

	// inclusive test against the 32x32 box
	assign in_box = (held_x >= bird_x) && (held_x <= bird_x + BOX_SPAN) &&
		(held_y >= BOX_TOP) && (held_y <= BOX_BOTTOM);

	assign collision = start_of_frame && shot_held && alive && in_box;

endmodule

//--- logic/game_ctrl.sv
`timescale 1ns/1ps

module game_ctrl
	import game_pkg::*;
(
	input logic clk,
	input logic resetN,
	input logic start_game,
	bird_ctrl_if.ctrl bus,
	input logic alive,
	output level_t level,
	output score_t score
);

	localparam score_t SCORE_MAX = '1;

	ctrl_state_t state;
	ctrl_state_t next_state;
	logic bird_gone; // frame clock found no bird left on screen
	logic level_up;

	assign bird_gone = bus.start_of_frame && !alive;
	assign level_up = (state == playing) && bird_gone && (level != LAST_LEVEL);

	always_comb begin
		next_state = state;
		case (state)
			wait_start: begin
				if (start_game) begin
					next_state = deploy_bird;
				end
			end
			deploy_bird: begin
				if (bus.start_of_frame) begin
					next_state = playing; // bird placed on this frame
				end
			end
			playing: begin
				if (bird_gone) begin
					next_state = (level == LAST_LEVEL) ? game_won : deploy_bird;
				end
			end
			game_won: begin
				next_state = game_won; // only reset leaves
			end
			default: begin
				next_state = wait_start;
			end
		endcase
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			state <= wait_start;
		end else begin
			state <= next_state;
		end
	end

	// level doubles as speed of the next bird
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			level <= '0;
		end else if (level_up) begin
			level <= level + 1'b1;
		end
	end

	// one point per hit, stuck at max
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			score <= '0;
		end else if (bus.collision && (score != SCORE_MAX)) begin
			score <= score + 1'b1;
		end
	end

	// deploy lines up with the frame clock the bird acts on
	assign bus.deploy = (state == deploy_bird) && bus.start_of_frame;
	assign bus.starting_life = life_t'(START_LIFE);
	assign bus.speed = speed_t'(level);

endmodule

//--- logic/bird_game_top.sv
`timescale 1ns/1ps

module bird_game_top
	import screen_pkg::*;
	import game_pkg::*;
#(
	parameter rand_t LFSR_SEED = 8'hA5,
	parameter rand_t RANDOM_OFFSET = '0
) (
	input logic clk,
	input logic resetN,
	input logic start_of_frame, // one clock per frame
	input logic start_game,
	input logic shot_valid,
	input coord_t shot_x,
	input coord_t shot_y,
	output coord_t bird_x,
	output coord_t bird_y,
	output logic bird_alive,
	output logic bird_red,
	output level_t level,
	output score_t score
);

	rand_t random;

	bird_ctrl_if bus_i ();

	assign bus_i.start_of_frame = start_of_frame;
	assign bird_y = coord_t'(BIRD_Y); // fixed flight row

	lfsr_random #(
		.LFSR_SEED(LFSR_SEED)
	) lfsr_random_i (
		.clk(clk),
		.resetN(resetN),
		.random(random)
	);

	bird_logic #(
		.RANDOM_OFFSET(RANDOM_OFFSET)
	) bird_logic_i (
		.clk(clk),
		.resetN(resetN),
		.bus(bus_i.bird),
		.random(random),
		.alive(bird_alive),
		.red(bird_red),
		.bird_x(bird_x)
	);

	hit_detect hit_detect_i (
		.clk(clk),
		.resetN(resetN),
		.start_of_frame(start_of_frame),
		.shot_valid(shot_valid),
		.shot_x(shot_x),
		.shot_y(shot_y),
		.alive(bird_alive),
		.bird_x(bird_x),
		.collision(bus_i.collision)
	);

	game_ctrl game_ctrl_i (
		.clk(clk),
		.resetN(resetN),
		.start_game(start_game),
		.bus(bus_i.ctrl),
		.alive(bird_alive),
		.level(level),
		.score(score)
	);

endmodule

//--- verif/bird_game_tb.sv
`timescale 1ns/1ps

module bird_game_tb
	import screen_pkg::*;
	import game_pkg::*;
();

	localparam rand_t LFSR_SEED = 8'hA5;
	localparam rand_t RANDOM_OFFSET = 8'h3C; // nonzero so the byte sum wraps
	localparam int CLK_PERIOD_NS = 4;
	localparam int RESET_CYCLES = 3;
	localparam int FRAME_CLKS = 20; // clocks between frame strobes
	localparam int NUM_FRAMES = 320; // enough for four levels plus idle frames
	localparam int START_FRAME = 2; // frames before start_game shoot at a dead bird
	localparam int WATCHDOG_NS = (NUM_FRAMES + 10) * FRAME_CLKS * CLK_PERIOD_NS;
	localparam int X_MAX_FIX = X_LIMIT * 64; // right stop in 1/64 pixel

	typedef enum logic [1:0] {move_idle, move_right, move_left} move_t;

	logic clk = 1'b0;
	logic resetN;
	logic start_of_frame;
	logic start_game;
	logic shot_valid;
	coord_t shot_x;
	coord_t shot_y;
	coord_t bird_x;
	coord_t bird_y;
	logic bird_alive;
	logic bird_red;
	level_t level;
	score_t score;

	integer seed;
	int frame_no; // for error lines
	int shot_clk;
	int extra_clk; // clock of a second shot in the frame or -1

	// reference model state
	rand_t m_lfsr;
	move_t m_wander;
	int m_x; // fixed point with 6 fraction bits
	int m_life;
	int m_red;
	level_t m_level;
	score_t m_score;
	ctrl_state_t m_state;
	logic m_held; // shot waiting for the frame strobe
	coord_t m_hx;
	coord_t m_hy;
	logic m_sof_prev; // last edge sampled a frame strobe
	logic m_deployed; // bird placed on the last frame strobe

	bird_game_top #(
		.LFSR_SEED(LFSR_SEED),
		.RANDOM_OFFSET(RANDOM_OFFSET)
	) bird_game_top_i (
		.clk(clk),
		.resetN(resetN),
		.start_of_frame(start_of_frame),
		.start_game(start_game),
		.shot_valid(shot_valid),
		.shot_x(shot_x),
		.shot_y(shot_y),
		.bird_x(bird_x),
		.bird_y(bird_y),
		.bird_alive(bird_alive),
		.bird_red(bird_red),
		.level(level),
		.score(score)
	);

	always #(CLK_PERIOD_NS / 2) clk = ~clk;

	task automatic abort_run();
		$display("** FAIL **");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic compare_coord(input string name, input coord_t exp, input coord_t act);
		if (exp !== act) begin
			$display("ERR %s (frame %0d): expected %0d, actual %0d", name, frame_no, exp, act);
			abort_run();
		end
	endtask

	task automatic compare_life_flag(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("ERR %s (frame %0d): expected %0b, actual %0b", name, frame_no, exp, act);
			abort_run();
		end
	endtask

	task automatic compare_level(input string name, input level_t exp, input level_t act);
		if (exp !== act) begin
			$display("ERR %s (frame %0d): expected %0d, actual %0d", name, frame_no, exp, act);
			abort_run();
		end
	endtask

	task automatic compare_score(input string name, input score_t exp, input score_t act);
		if (exp !== act) begin
			$display("ERR %s (frame %0d): expected %0d, actual %0d", name, frame_no, exp, act);
			abort_run();
		end
	endtask

	// one clock of the whole subsystem with the inputs the dut sampled
	task automatic model_step();
		rand_t rnd;
		rand_t ofs;
		int step;
		int bx;
		logic alive_now;
		logic col;
		logic dep;
		if (!resetN) begin
			m_lfsr = LFSR_SEED;
			m_wander = move_idle;
			m_x = 0;
			m_life = 0;
			m_red = 0;
			m_level = '0;
			m_score = '0;
			m_state = wait_start;
			m_held = 1'b0;
			m_sof_prev = 1'b0;
			m_deployed = 1'b0;
		end else begin
			rnd = m_lfsr;
			m_lfsr = {1'b0, m_lfsr[7:1]} ^ (m_lfsr[0] ? 8'hB8 : 8'h00); // galois step right
			m_sof_prev = start_of_frame;
			alive_now = (m_life != 0) || (m_red != 0);
			bx = m_x / 64;
			col = start_of_frame && m_held && alive_now &&
				(int'(m_hx) >= bx) && (int'(m_hx) <= bx + SPRITE_SIZE - 1) &&
				(int'(m_hy) >= BIRD_Y) && (int'(m_hy) <= BIRD_Y + SPRITE_SIZE - 1);
			dep = (m_state == deploy_bird) && start_of_frame;
			if (start_of_frame) begin
				m_deployed = dep;
				ofs = rnd + RANDOM_OFFSET; // 8 bit sum wraps mod 256
				step = 50 + 20 * int'(m_level); // speed follows level
				case (m_wander) // move with the direction of the past frame
					move_right: begin
						if (m_x < X_MAX_FIX) begin
							m_x = (m_x + step > X_MAX_FIX) ? X_MAX_FIX : m_x + step;
						end
					end
					move_left: begin
						if (m_x > 0) begin
							m_x = (m_x < step) ? 0 : m_x - step;
						end
					end
					default: ;
				endcase
				if (ofs < rand_t'(CHANCE_TO_CHANGE)) begin
					if (m_wander == move_idle) begin
						m_wander = (ofs < rand_t'(4)) ? move_right : move_left;
					end else begin
						m_wander = move_idle;
					end
				end
				if (dep) begin
					m_x = INITIAL_X * 64;
				end
				if (col) begin
					if (m_life != 0) begin
						m_life = m_life - 1;
					end
					m_red = RED_FRAMES; // flashing restarts on every hit
				end else begin
					if (dep) begin
						m_life = START_LIFE;
					end
					if (m_red != 0) begin
						m_red = m_red - 1;
					end
				end
			end
			if (start_of_frame) begin
				m_held = 1'b0; // shot on the strobe clock is lost
			end else if (shot_valid) begin
				m_held = 1'b1;
				m_hx = shot_x;
				m_hy = shot_y;
			end
			if (col && (m_score != 8'hFF)) begin
				m_score = m_score + 8'd1;
			end
			case (m_state)
				wait_start: begin
					if (start_game) begin
						m_state = deploy_bird;
					end
				end
				deploy_bird: begin
					if (start_of_frame) begin
						m_state = playing;
					end
				end
				playing: begin
					if (start_of_frame && !alive_now) begin
						if (m_level == level_t'(3)) begin
							m_state = game_won;
						end else begin
							m_level = m_level + 2'd1;
							m_state = deploy_bird;
						end
					end
				end
				default: ;
			endcase
		end
	endtask

	task automatic run_checks();
		compare_coord("bird_x", coord_t'(m_x / 64), bird_x);
		compare_coord("bird_y", coord_t'(BIRD_Y), bird_y);
		compare_life_flag("bird_alive", (m_life != 0) || (m_red != 0), bird_alive);
		compare_life_flag("bird_red", m_red != 0, bird_red);
		compare_level("level", m_level, level);
		compare_score("score", m_score, score);
		if ((int'(bird_x) < 0) || (int'(bird_x) > X_LIMIT)) begin
			$display("bird_x %0d is off the allowed range in frame %0d", bird_x, frame_no);
			abort_run();
		end
		if (m_deployed) begin // fresh bird always starts mid screen
			compare_coord("deploy x", coord_t'(INITIAL_X), bird_x);
			compare_life_flag("deploy alive", 1'b1, bird_alive);
		end
	endtask

	// aimed shots only while the bird has lives so that red can run out
	task automatic pick_shot();
		int bx;
		int rx;
		int ry;
		bx = m_x / 64;
		if (($random(seed) & 1) && ((m_life != 0) || (frame_no < START_FRAME))) begin
			rx = bx + int'($unsigned($random(seed)) % SPRITE_SIZE);
			ry = BIRD_Y + int'($unsigned($random(seed)) % SPRITE_SIZE);
		end else begin
			rx = int'($unsigned($random(seed)) % SCREEN_WIDTH);
			ry = int'($unsigned($random(seed)) % SCREEN_HEIGHT);
		end
		shot_x <= coord_t'(rx);
		shot_y <= coord_t'(ry);
	endtask

	always @(posedge clk) begin
		model_step();
	end

	always @(negedge clk) begin
		if (resetN && m_sof_prev) begin
			run_checks(); // one clock after each strobe
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		abort_run();
	end

	initial begin
		seed = 32'h737d_fba6;
		frame_no = 0;
		resetN <= 1'b0;
		start_of_frame <= 1'b0;
		start_game <= 1'b0;
		shot_valid <= 1'b0;
		shot_x <= '0;
		shot_y <= '0;
		repeat (RESET_CYCLES) @(posedge clk);
		resetN <= 1'b1;
		@(negedge clk);
		compare_coord("reset bird_x", coord_t'(0), bird_x);
		compare_coord("reset bird_y", coord_t'(BIRD_Y), bird_y);
		compare_life_flag("reset bird_alive", 1'b0, bird_alive);
		compare_life_flag("reset bird_red", 1'b0, bird_red);
		compare_level("reset level", level_t'(0), level);
		compare_score("reset score", score_t'(0), score);
		for (frame_no = 0; frame_no < NUM_FRAMES; frame_no++) begin
			shot_clk = 2 + int'($unsigned($random(seed)) % 18); // after the strobe settles
			extra_clk = -1;
			if (($unsigned($random(seed)) % 4) == 0) begin
				extra_clk = 2 + int'($unsigned($random(seed)) % 18); // may overwrite
			end
			for (int c = 0; c < FRAME_CLKS; c++) begin
				@(posedge clk);
				start_of_frame <= (c == 0);
				start_game <= (frame_no == START_FRAME) && (c == 5);
				if ((c == shot_clk) || (c == extra_clk)) begin
					shot_valid <= 1'b1;
					pick_shot();
				end else begin
					shot_valid <= 1'b0;
				end
			end
		end
		@(posedge clk);
		shot_valid <= 1'b0;
		@(negedge clk);
		if (m_state != game_won) begin
			$display("the game did not clear level 3 within %0d frames", NUM_FRAMES);
			abort_run();
		end else begin
			compare_level("final level", level_t'(3), level);
			compare_life_flag("final bird_alive", 1'b0, bird_alive);
			$display("** PASS **");
			$finish;
		end
	end

endmodule

//--- bird_game.f
logic/screen_pkg.sv
logic/game_pkg.sv
logic/bird_ctrl_if.sv
logic/lfsr_random.sv
logic/bird_logic.sv
logic/hit_detect.sv
logic/game_ctrl.sv
logic/bird_game_top.sv
verif/bird_game_tb.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing -j 0
TOP      := bird_game_tb
FILELIST := bird_game.f
BUILD    := obj_dir
LOG      := sim.log
PASS_MSG := ^\*\* PASS \*\*$$

SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with $(SIM), run $(TOP) and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD) and $(LOG)"

$(BUILD)/V$(TOP): $(FILELIST) $(SOURCES)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

test: $(BUILD)/V$(TOP)
	-./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q '$(PASS_MSG)' $(LOG); then \
		echo "test passed"; \
	else \
		echo "test failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
